// ==== hw/execUnit_params.svh ====
// widths fixed for a 16-bit core; changing EXEC_WORD_W alone will not rescale shifter or divider
`ifndef EXEC_UNIT_PARAMS_SVH
`define EXEC_UNIT_PARAMS_SVH

// --------------------
// data widths
// --------------------
`define EXEC_WORD_W 16     // full data word
`define EXEC_BYTE_W 8      // byte lane, low half of a word

// shift count, taken from rf2 bits 4:0
`define EXEC_AMT_W 5

// --------------------
// divider
// --------------------
`define EXEC_DIV_CNT_W 5   // must hold EXEC_WORD_STEPS
`define EXEC_WORD_STEPS 16 // one quotient bit per step
`define EXEC_BYTE_STEPS 8

// constant operand source, used for inc/dec by two
`define EXEC_CONST_TWO 2

`endif

// ==== hw/execPkg.sv ====
// shared types only; widths come from execUnit_params.svh, which must be on the include path
`include "execUnit_params.svh"

package execPkg;

	// --------------------
	// data vectors
	// --------------------
	typedef logic [`EXEC_WORD_W-1:0]   word_t;
	typedef logic [`EXEC_BYTE_W-1:0]   byte_t;
	typedef logic [`EXEC_WORD_W:0]     aluRes_t; // carry sits in the top bit
	typedef logic [2*`EXEC_WORD_W-1:0] dword_t;  // dx:operand two
	typedef logic [`EXEC_AMT_W-1:0]    shAmt_t;
	typedef logic [`EXEC_DIV_CNT_W-1:0] divCnt_t;

	// --------------------
	// control encodings
	// --------------------
	typedef enum logic [1:0] {OPSEL_RF, OPSEL_MEM, OPSEL_IMM, OPSEL_TWO} opSel_t;

	typedef enum logic [2:0] {EXEC_NOP, EXEC_ALU, EXEC_SHIFT, EXEC_DIV, EXEC_REMAINDER} execOp_t;

	// low 3 bits follow the x86 group-1 order
	typedef enum logic [3:0] {
		ALU_ADD, ALU_OR, ALU_ADC, ALU_SBB, ALU_AND, ALU_SUB, ALU_XOR, ALU_CMP,
		ALU_INC, ALU_DEC, ALU_NOT, ALU_NEG, ALU_TEST, ALU_PASS1, ALU_PASS2, ALU_SHL2
	} aluFunc_t;

	// bit0 right, bit1 through carry / arithmetic, bit2 shift rather than rotate
	typedef enum logic [2:0] {SH_ROL, SH_ROR, SH_RCL, SH_RCR, SH_SHL, SH_SHR, SH_SAL, SH_SAR} shFunc_t;

	typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_FINISH} divState_t;

endpackage

// ==== hw/execAlu.sv ====
// purely combinational; carry out is a borrow for the subtract group, zero for the logic ops
`timescale 1ns/10ps
`include "execUnit_params.svh"

module execAlu import execPkg::*;
(
	input  word_t    op1_i,
	input  word_t    op2_i,
	input  aluFunc_t func_i,
	input  logic     carry_i,
	output aluRes_t  res_o
);

	logic   isSub;  // subtract group
	logic   useCy;  // adc / sbb only
	logic   cyIn;
	word_t  op2Inv;
	logic [`EXEC_WORD_W+1:0] sum; // extra lsb carries cyIn into the add

	always_comb
	begin
		isSub  = (func_i == ALU_SBB) || (func_i == ALU_SUB) || (func_i == ALU_CMP);
		useCy  = (func_i == ALU_ADC) || (func_i == ALU_SBB);
		op2Inv = isSub ? ~op2_i : op2_i;
		cyIn   = isSub ^ (carry_i & useCy); // a-b = a+~b+1, borrow eats the +1

		// one adder for all five arithmetic codes
		sum = {1'b0, op1_i, cyIn} + {1'b0, op2Inv, cyIn};

		case (func_i)
			ALU_ADD,
			ALU_ADC,
			ALU_SBB,
			ALU_SUB,
			ALU_CMP:   res_o = {sum[`EXEC_WORD_W+1] ^ isSub, sum[`EXEC_WORD_W:1]}; // borrow view
			ALU_OR:    res_o = {1'b0, op1_i | op2_i};
			ALU_AND:   res_o = {1'b0, op1_i & op2_i};
			ALU_XOR:   res_o = {1'b0, op1_i ^ op2_i};

			// --------------------
			// unary and pass group
			// --------------------
			ALU_INC:   res_o = {1'b0, op1_i} + aluRes_t'(1);
			ALU_DEC:   res_o = {1'b0, op1_i} - aluRes_t'(1);
			ALU_NOT:   res_o = {1'b0, ~op1_i};
			ALU_NEG:   res_o = {1'b1, ~op1_i} + aluRes_t'(1); // carry clears only for neg 0
			ALU_TEST:  res_o = {1'b0, op1_i & op2_i};
			ALU_PASS1: res_o = {1'b0, op1_i};
			ALU_PASS2: res_o = {1'b0, op2_i};
			ALU_SHL2:  res_o = {1'b0, op2_i} << 2; // bit 14 lands in carry
			default:   res_o = '0;
		endcase
	end

endmodule

// ==== hw/execShifter.sv ====
// combinational; count is taken as given, no shift-by-one mode, byte results zero the high byte
`timescale 1ns/10ps
`include "execUnit_params.svh"

module execShifter import execPkg::*;
(
	input  word_t   data_i,
	input  shAmt_t  amount_i,
	input  shFunc_t func_i,
	input  logic    bw_i,     // word when high
	input  logic    carry_i,
	output word_t   res_o,
	output logic    carry_o,
	output logic    overflow_o
);

	localparam int W = `EXEC_WORD_W;
	localparam int B = `EXEC_BYTE_W;

	shAmt_t cnt;
	word_t  dataBw;  // byte copied into both halves so rotates wrap for free
	word_t  fillL;
	word_t  fillR;
	logic [2*W:0] shL; // carry : data : fill
	logic [2*W:0] shR; // fill : data : carry
	logic   isRight;
	logic   topBit;
	logic   nextBit;

	always_comb
	begin
		isRight = func_i[0];

		// rcl / rcr go round a 9 or 17 bit ring
		if ((func_i == SH_RCL) || (func_i == SH_RCR))
			cnt = bw_i ? amount_i % shAmt_t'(17) : amount_i % shAmt_t'(9);
		else
			cnt = bw_i ? {1'b0, amount_i[3:0]} : {2'b0, amount_i[2:0]};

		dataBw = bw_i ? data_i : {data_i[B-1:0], data_i[B-1:0]};

		// --------------------
		// fill patterns
		// --------------------
		if (func_i[2])
			fillL = '0;                              // shl / sal
		else
			fillL = func_i[1] ? {carry_i, dataBw[W-1:1]} : dataBw;

		if (func_i[2])
			fillR = func_i[1] ? {W{dataBw[W-1]}} : '0; // sar sign fill
		else
			fillR = func_i[1] ? {dataBw[W-2:0], carry_i} : dataBw;

		shL = {carry_i, dataBw, fillL} << cnt;
		shR = {fillR, dataBw, carry_i} >> cnt;

		// result and last bit out
		if (bw_i)
		begin
			res_o   = isRight ? shR[W:1] : shL[2*W-1:W];
			carry_o = isRight ? shR[0] : shL[2*W];
		end
		else
		begin
			res_o   = {{(W-B){1'b0}}, (isRight ? shR[W:B+1] : shL[W+B-1:W])};
			carry_o = isRight ? shR[B] : shL[W+B];
		end

		// overflow from the input operand
		topBit  = bw_i ? data_i[W-1] : data_i[B-1];
		nextBit = bw_i ? data_i[W-2] : data_i[B-2];
		case (func_i)
			SH_ROR:  overflow_o = topBit ^ data_i[0];
			SH_RCR:  overflow_o = topBit ^ carry_i;
			SH_SHR:  overflow_o = topBit;
			SH_SAR:  overflow_o = 1'b0;
			default: overflow_o = topBit ^ nextBit; // all left moves
		endcase
	end

endmodule

// ==== hw/divCtrl.sv ====
// one divide at a time; start is ignored unless idle, stall freezes every state
`timescale 1ns/10ps
`include "execUnit_params.svh"

module divCtrl import execPkg::*;
(
	input  logic iClk,
	input  logic rstN_i,
	input  logic start_i,
	input  logic stall_i,
	input  logic ovf_i,      // valid with start_i
	input  logic lastStep_i,
	output logic load_o,
	output logic step_o,
	output logic done_o,
	output logic err_o
);

	divState_t state;
	logic      errSeen; // overflow caught at load

	assign load_o = (state == DIV_IDLE) && start_i;
	assign step_o = (state == DIV_RUN) && !stall_i;
	assign done_o = (state == DIV_FINISH) && !stall_i;
	assign err_o  = done_o && errSeen;

	always_ff @(posedge iClk or negedge rstN_i)
	begin
		if (!rstN_i)
		begin
			state   <= DIV_IDLE;
			errSeen <= 1'b0;
		end
		else
		begin
			case (state)
				DIV_IDLE:
				begin
					if (load_o)
					begin
						state   <= ovf_i ? DIV_FINISH : DIV_RUN; // skip the steps on overflow
						errSeen <= ovf_i;
					end
				end
				DIV_RUN:    if (step_o && lastStep_i) state <= DIV_FINISH;
				DIV_FINISH: if (done_o) state <= DIV_IDLE;
				default:    state <= DIV_IDLE;
			endcase
		end
	end

endmodule

// ==== hw/divStepCounter.sv ====
// counts down only on step_i, so a stalled step is simply not counted
`timescale 1ns/10ps
`include "execUnit_params.svh"

module divStepCounter import execPkg::*;
(
	input  logic iClk,
	input  logic rstN_i,
	input  logic load_i,
	input  logic bw_i,
	input  logic step_i,
	output logic lastStep_o
);

	divCnt_t stepsLeft;

	assign lastStep_o = (stepsLeft == divCnt_t'(1));

	always_ff @(posedge iClk or negedge rstN_i)
	begin
		if (!rstN_i)
			stepsLeft <= '0;
		else if (load_i)
			stepsLeft <= bw_i ? divCnt_t'(`EXEC_WORD_STEPS) : divCnt_t'(`EXEC_BYTE_STEPS);
		else if (step_i)
			stepsLeft <= stepsLeft - divCnt_t'(1); // one quotient bit per step
	end

endmodule

// ==== hw/divDatapath.sv ====
// unsigned only; byte divide expects the divisor zero-extended from its low byte
`timescale 1ns/10ps
`include "execUnit_params.svh"

module divDatapath import execPkg::*;
(
	input  logic   iClk,
	input  logic   rstN_i,
	input  logic   load_i,
	input  logic   step_i,
	input  logic   bw_i,
	input  dword_t dividend_i, // dx:op2, byte mode uses op2 only
	input  word_t  divisor_i,
	output logic   ovf_o,
	output word_t  quot_o,
	output word_t  rem_o
);

	localparam int W = `EXEC_WORD_W;
	localparam int B = `EXEC_BYTE_W;

	word_t remQ;
	word_t quotQ;   // unprocessed dividend bits shift out the top
	word_t divisorQ;
	word_t hiHalf;
	logic [W:0] trial; // shifted remainder minus divisor, msb is the borrow

	assign hiHalf = bw_i ? dividend_i[2*W-1:W] : {{(W-B){1'b0}}, dividend_i[W-1:B]};
	assign ovf_o  = load_i && (hiHalf >= divisor_i); // also catches divide by zero
	assign trial  = {remQ, quotQ[W-1]} - {1'b0, divisorQ};
	assign quot_o = quotQ;
	assign rem_o  = remQ;

	always_ff @(posedge iClk or negedge rstN_i)
	begin
		if (!rstN_i)
		begin
			remQ     <= '0;
			quotQ    <= '0;
			divisorQ <= '0;
		end
		else if (load_i)
		begin
			remQ     <= hiHalf;
			quotQ    <= bw_i ? dividend_i[W-1:0] : {dividend_i[B-1:0], {B{1'b0}}};
			divisorQ <= divisor_i;
		end
		else if (step_i)
		begin
			// restoring step, keep the difference only if it did not borrow
			remQ  <= trial[W] ? {remQ[W-2:0], quotQ[W-1]} : trial[W-1:0];
			quotQ <= {quotQ[W-2:0], ~trial[W]};
		end
	end

endmodule

// ==== hw/execUnit.sv ====
// caller holds EXEC_NOP while stallD_o is high; ALU ops clear overflow, flags come elsewhere
`timescale 1ns/10ps
`include "execUnit_params.svh"

module execUnit import execPkg::*;
(
	input  logic     iClk,
	input  logic     rstN_i,
	input  execOp_t  exec_i,
	input  aluFunc_t func_i,   // low 3 bits double as shFunc_t
	input  logic     bw_i,
	input  opSel_t   selIn1_i,
	input  opSel_t   selIn2_i,
	input  word_t    rf1_i,
	input  word_t    rf2_i,
	input  word_t    mem_i,
	input  word_t    imm1_i,
	input  word_t    imm2_i,
	input  word_t    dx_i,
	input  logic     carry_i,
	input  logic     stall_i,
	output word_t    result_o,
	output logic     isZero_o,
	output logic     carry_o,
	output logic     overflow_o,
	output logic     stallD_o,
	output logic     divErr_o
);

	word_t   op1;
	word_t   op2;
	aluRes_t aluRes;
	word_t   shRes;
	logic    shCarry;
	logic    shOvf;
	byte_t   divisorByte;
	word_t   divisor;
	logic    divStart;
	logic    divLoad;
	logic    divStep;
	logic    divDone;
	logic    divErr;
	logic    divOvf;
	logic    lastStep;
	word_t   quot;
	word_t   rem;
	byte_t   remByte;
	byte_t   quotByte;
	word_t   resultQ;
	word_t   remQ;       // remainder of the last divide
	logic    carryQ;
	logic    ovfQ;
	logic    stallDQ;
	logic    divErrQ;
	logic    divBwQ;

	// --------------------
	// operand select
	// --------------------
	always_comb
	begin
		case (selIn1_i)
			OPSEL_RF:  op1 = rf1_i;
			OPSEL_MEM: op1 = mem_i;
			OPSEL_IMM: op1 = imm2_i;  // imm2 on this side
			default:   op1 = word_t'(`EXEC_CONST_TWO);
		endcase
		case (selIn2_i)
			OPSEL_RF:  op2 = rf2_i;
			OPSEL_MEM: op2 = mem_i;
			OPSEL_IMM: op2 = imm1_i;
			default:   op2 = word_t'(`EXEC_CONST_TWO);
		endcase
	end

	assign divisorByte = op1[`EXEC_BYTE_W-1:0];
	assign divisor     = bw_i ? op1 : {{(`EXEC_WORD_W-`EXEC_BYTE_W){1'b0}}, divisorByte};
	assign divStart    = (exec_i == EXEC_DIV) && !stallDQ; // single strobe, busy blocks repeats
	assign remByte     = rem[`EXEC_BYTE_W-1:0];
	assign quotByte    = quot[`EXEC_BYTE_W-1:0];

	execAlu uAlu (.op1_i(op1), .op2_i(op2), .func_i(func_i), .carry_i(carry_i), .res_o(aluRes));

	execShifter uShifter
	(
		.data_i(op1), .amount_i(rf2_i[`EXEC_AMT_W-1:0]), .func_i(shFunc_t'(func_i[2:0])),
		.bw_i(bw_i), .carry_i(carry_i), .res_o(shRes), .carry_o(shCarry), .overflow_o(shOvf)
	);

	divCtrl uDivCtrl
	(
		.iClk(iClk), .rstN_i(rstN_i), .start_i(divStart), .stall_i(stall_i), .ovf_i(divOvf),
		.lastStep_i(lastStep), .load_o(divLoad), .step_o(divStep), .done_o(divDone),
		.err_o(divErr)
	);

	divStepCounter uDivCnt
	(
		.iClk(iClk), .rstN_i(rstN_i), .load_i(divLoad), .bw_i(bw_i), .step_i(divStep),
		.lastStep_o(lastStep)
	);

	divDatapath uDivData
	(
		.iClk(iClk), .rstN_i(rstN_i), .load_i(divLoad), .step_i(divStep), .bw_i(bw_i),
		.dividend_i({dx_i, op2}), .divisor_i(divisor), .ovf_o(divOvf), .quot_o(quot),
		.rem_o(rem)
	);

	// --------------------
	// result register
	// --------------------
	always_ff @(posedge iClk or negedge rstN_i)
	begin
		if (!rstN_i)
		begin
			resultQ <= '0;
			remQ    <= '0;
			carryQ  <= 1'b0;
			ovfQ    <= 1'b0;
			stallDQ <= 1'b0;
			divErrQ <= 1'b0;
			divBwQ  <= 1'b0;
		end
		else
		begin
			divErrQ <= divErr; // one cycle, lines up with the fall of stallD
			if (divStart)
			begin
				stallDQ <= 1'b1;
				divBwQ  <= bw_i;
			end
			if (divDone)
			begin
				stallDQ <= 1'b0;
				remQ    <= rem;
				resultQ <= divBwQ ? quot : {remByte, quotByte}; // byte: ah=rem, al=quot
			end
			if (exec_i == EXEC_ALU)
			begin
				resultQ <= aluRes[`EXEC_WORD_W-1:0];
				carryQ  <= aluRes[`EXEC_WORD_W];
				ovfQ    <= 1'b0;
			end
			else if (exec_i == EXEC_SHIFT)
			begin
				resultQ <= shRes;
				carryQ  <= shCarry;
				ovfQ    <= shOvf;
			end
			else if (exec_i == EXEC_REMAINDER)
				resultQ <= remQ;
		end
	end

	assign result_o   = resultQ;
	assign isZero_o   = (resultQ == '0);
	assign carry_o    = carryQ;
	assign overflow_o = ovfQ;
	assign stallD_o   = stallDQ;
	assign divErr_o   = divErrQ;

endmodule

// ==== sim/execUnitTb.sv ====
// directed tests only; shift carry is not checked for a zero count, divide error results are not checked
`timescale 1ns/10ps
`include "execUnit_params.svh"

module execUnitTb import execPkg::*;
();

	localparam int TIMEOUT = 40; // cycles per wait on stallD_o

	logic     iClk;
	logic     rstN_i;
	execOp_t  exec_i;
	aluFunc_t func_i;
	logic     bw_i;
	opSel_t   selIn1_i;
	opSel_t   selIn2_i;
	word_t    rf1_i;
	word_t    rf2_i;
	word_t    mem_i;
	word_t    imm1_i;
	word_t    imm2_i;
	word_t    dx_i;
	logic     carry_i;
	logic     stall_i;
	word_t    result_o;
	logic     isZero_o;
	logic     carry_o;
	logic     overflow_o;
	logic     stallD_o;
	logic     divErr_o;
	logic [31:0] rngState;
	int       errorCount;

	execUnit dut (.*);

	initial
	begin
		iClk = 1'b0;
		forever #2 iClk = ~iClk; // 4 ns period
	end

	// --------------------
	// helpers and checks
	// --------------------
	function automatic logic [31:0] nextRand();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13); // xorshift32
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	task automatic failStop(input string msg);
		errorCount++;
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic checkWord(input word_t got, input word_t exp, input string what);
		if (got !== exp)
			failStop($sformatf("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp));
	endtask

	task automatic checkBit(input logic got, input logic exp, input string what);
		if (got !== exp)
			failStop($sformatf("MISMATCH at %0t ns: %s got %b expected %b", $time, what, got, exp));
	endtask

	// --------------------
	// reference model
	// --------------------
	function automatic word_t pickOp1(opSel_t s, word_t rf, word_t m, word_t imm2);
		case (s)
			OPSEL_RF:  return rf;
			OPSEL_MEM: return m;
			OPSEL_IMM: return imm2; // operand one takes imm2
			default:   return word_t'(`EXEC_CONST_TWO);
		endcase
	endfunction

	function automatic word_t pickOp2(opSel_t s, word_t rf, word_t m, word_t imm1);
		case (s)
			OPSEL_RF:  return rf;
			OPSEL_MEM: return m;
			OPSEL_IMM: return imm1;
			default:   return word_t'(`EXEC_CONST_TWO);
		endcase
	endfunction

	// bit 16 of s is carry, a borrow for the subtracts
	function automatic aluRes_t aluModel(aluFunc_t f, word_t a, word_t b, logic cin);
		logic [31:0] s;
		case (f)
			ALU_ADD:   s = a + b;
			ALU_ADC:   s = a + b + cin;
			ALU_SUB,
			ALU_CMP:   s = {15'b0, a < b, word_t'(a - b)};
			ALU_SBB:   s = {15'b0, a < ({1'b0, b} + cin), word_t'(a - b - cin)};
			ALU_OR:    s = a | b;
			ALU_AND,
			ALU_TEST:  s = a & b;
			ALU_XOR:   s = a ^ b;
			ALU_INC:   s = {15'b0, a == 16'hffff, word_t'(a + 16'd1)};
			ALU_DEC:   s = {15'b0, a == 16'h0000, word_t'(a - 16'd1)};
			ALU_NOT:   s = {16'b0, ~a};
			ALU_NEG:   s = {15'b0, a != 16'h0000, word_t'(16'd0 - a)}; // x86 cf for neg
			ALU_PASS1: s = a;
			ALU_PASS2: s = b;
			default:   s = {15'b0, b[14], b[13:0], 2'b00}; // shl2
		endcase
		return aluRes_t'(s[16:0]);
	endfunction

	// one bit per loop pass, ring of w or w+1 bits
	task automatic shiftModel(input word_t data, input shAmt_t amt, input shFunc_t f,
		input logic bw, input logic cin, output word_t res, output logic cOut,
		output logic ovf, output int cnt);
		int    w;
		word_t d;
		word_t mask;
		logic  c;
		logic  nc;
		w    = bw ? 16 : 8;
		mask = bw ? 16'hffff : 16'h00ff;
		d    = data & mask;
		cnt  = ((f == SH_RCL) || (f == SH_RCR)) ? amt % (w + 1) : amt % w;
		c    = cin;
		case (f)
			SH_ROR:  ovf = d[w-1] ^ d[0];
			SH_RCR:  ovf = d[w-1] ^ cin;
			SH_SHR:  ovf = d[w-1];
			SH_SAR:  ovf = 1'b0;
			default: ovf = d[w-1] ^ d[w-2];
		endcase
		for (int i = 0; i < cnt; i++)
		begin
			nc = (f[0]) ? d[0] : d[w-1]; // bit leaving the ring
			case (f)
				SH_ROL:  d = ((d << 1) | nc) & mask;
				SH_ROR:  d = (d >> 1) | (word_t'(nc) << (w - 1));
				SH_RCL:  d = ((d << 1) | c) & mask;
				SH_RCR:  d = (d >> 1) | (word_t'(c) << (w - 1));
				SH_SAR:  d = (d >> 1) | (word_t'(d[w-1]) << (w - 1));
				SH_SHR:  d = d >> 1;
				default: d = (d << 1) & mask;
			endcase
			c = nc;
		end
		res  = d;
		cOut = c;
	endtask

	// --------------------
	// stimulus
	// --------------------
	task automatic applyOp(input execOp_t op, input aluFunc_t f, input logic bw,
		input opSel_t s1, input opSel_t s2, input logic cin, input word_t a, input word_t b,
		input word_t m, input word_t i1, input word_t i2, input word_t d);
		@(posedge iClk);
		exec_i   <= op;
		func_i   <= f;
		bw_i     <= bw;
		selIn1_i <= s1;
		selIn2_i <= s2;
		carry_i  <= cin;
		rf1_i    <= a;
		rf2_i    <= b;
		mem_i    <= m;
		imm1_i   <= i1;
		imm2_i   <= i2;
		dx_i     <= d;
		@(posedge iClk);
		exec_i   <= EXEC_NOP; // result latched at this edge
		@(negedge iClk);
	endtask

	task automatic aluCase(input aluFunc_t f, input opSel_t s1, input opSel_t s2, input logic cin);
		word_t   a;
		word_t   b;
		word_t   m;
		word_t   i1;
		word_t   i2;
		aluRes_t exp;
		a   = word_t'(nextRand());
		b   = word_t'(nextRand());
		m   = word_t'(nextRand());
		i1  = word_t'(nextRand());
		i2  = word_t'(nextRand());
		exp = aluModel(f, pickOp1(s1, a, m, i2), pickOp2(s2, b, m, i1), cin);
		applyOp(EXEC_ALU, f, 1'b1, s1, s2, cin, a, b, m, i1, i2, 16'h0000);
		checkWord(result_o, exp[15:0], $sformatf("%s result", f.name()));
		checkBit(carry_o, exp[16], $sformatf("%s carry", f.name()));
		checkBit(isZero_o, exp[15:0] == 16'h0000, $sformatf("%s zero flag", f.name()));
	endtask

	task automatic shiftCase(input shFunc_t f, input logic bw, input shAmt_t amt);
		logic [31:0] r;
		word_t a;
		word_t er;
		logic  ec;
		logic  eo;
		int    cnt;
		r = nextRand();
		a = word_t'(r[31:16]);
		shiftModel(a, amt, f, bw, r[0], er, ec, eo, cnt);
		applyOp(EXEC_SHIFT, aluFunc_t'({1'b0, f}), bw, OPSEL_RF, OPSEL_RF, r[0], a,
			word_t'(amt), 16'h0000, 16'h0000, 16'h0000, 16'h0000);
		checkWord(result_o, er, $sformatf("%s bw=%b amt=%0d result", f.name(), bw, amt));
		if (cnt != 0)
			checkBit(carry_o, ec, $sformatf("%s bw=%b amt=%0d carry", f.name(), bw, amt));
		checkBit(overflow_o, eo, $sformatf("%s bw=%b overflow", f.name(), bw));
		checkBit(isZero_o, er == 16'h0000, "shift zero flag");
	endtask

	// byte mode divides num by den[7:0]; hold > 0 stalls mid-divide
	task automatic divCase(input logic bw, input word_t dx, input word_t num, input word_t den,
		input int hold);
		logic [31:0] dividend;
		logic [31:0] divisor;
		logic [31:0] q;
		logic [31:0] r;
		logic        expErr;
		word_t       expRes;
		int          cycles;
		time         startT;
		int          busyCycles;
		dividend = bw ? {dx, num} : {16'h0000, num};
		divisor  = bw ? {16'h0000, den} : {24'h000000, den[7:0]};
		expErr   = (divisor == 0) || ((dividend / divisor) > (bw ? 32'hffff : 32'h00ff));
		q = 0;
		r = 0;
		if (!expErr)
		begin
			q = dividend / divisor;
			r = dividend % divisor;
		end
		expRes = bw ? q[15:0] : {r[7:0], q[7:0]}; // byte: ah rem, al quot
		applyOp(EXEC_DIV, ALU_ADD, bw, OPSEL_RF, OPSEL_RF, 1'b0, den, num, 16'h0000,
			16'h0000, 16'h0000, dx);
		startT = $time;
		checkBit(stallD_o, 1'b1, "stallD after divide start");
		if (hold > 0)
		begin
			repeat (3) @(posedge iClk); // a few steps in
			stall_i <= 1'b1;
			for (int i = 0; i < hold; i++)
			begin
				@(negedge iClk);
				checkBit(stallD_o, 1'b1, "stallD under stall");
				@(posedge iClk);
			end
			stall_i <= 1'b0;
			@(negedge iClk);
		end
		cycles = 0;
		while (stallD_o === 1'b1)
		begin
			checkBit(divErr_o, 1'b0, "divErr while busy");
			@(negedge iClk);
			cycles++;
			if (cycles > TIMEOUT)
				failStop("timeout: stallD_o stayed high for more than 40 cycles");
		end
		// one step per unstalled cycle, stalled cycles add on top
		busyCycles = int'(($time - startT) / 4);
		if (!expErr && (busyCycles < (bw ? 16 : 8) + hold))
			failStop("divide ended before every step and every stalled cycle had passed");
		checkBit(divErr_o, expErr, "divErr at end of divide");
		if (expErr)
		begin
			@(negedge iClk);
			checkBit(divErr_o, 1'b0, "divErr pulse longer than one cycle");
		end
		else
		begin
			checkWord(result_o, expRes, $sformatf("divide bw=%b result", bw));
			applyOp(EXEC_REMAINDER, ALU_ADD, bw, OPSEL_RF, OPSEL_RF, 1'b0, 16'h0000,
				16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000);
			checkWord(result_o, r[15:0], "remainder readout");
			checkBit(isZero_o, r == 0, "remainder zero flag");
		end
	endtask

	// --------------------
	// test groups
	// --------------------
	task automatic resetCheck();
		checkWord(result_o, 16'h0000, "result after reset");
		checkBit(isZero_o, 1'b1, "zero flag after reset");
		checkBit(carry_o, 1'b0, "carry after reset");
		checkBit(overflow_o, 1'b0, "overflow after reset");
		checkBit(stallD_o, 1'b0, "stallD after reset");
		checkBit(divErr_o, 1'b0, "divErr after reset");
	endtask

	task automatic aluTests();
		for (int f = 0; f < 16; f++)
		begin
			for (int s = 0; s < 4; s++)
				aluCase(aluFunc_t'(f), opSel_t'(s), opSel_t'(3 - s), s[0]); // every source
		end
		aluCase(ALU_ADC, OPSEL_RF, OPSEL_RF, 1'b1);
		aluCase(ALU_SBB, OPSEL_RF, OPSEL_IMM, 1'b1);
		aluCase(ALU_XOR, OPSEL_MEM, OPSEL_MEM, 1'b0); // zero result
		aluCase(ALU_SUB, OPSEL_TWO, OPSEL_TWO, 1'b1);
	endtask

	task automatic shiftTests();
		logic [31:0] r;
		for (int bw = 0; bw < 2; bw++)
		begin
			for (int f = 0; f < 8; f++)
			begin
				r = nextRand();
				shiftCase(shFunc_t'(f), bw[0], shAmt_t'(r[4:0]));
				shiftCase(shFunc_t'(f), bw[0], shAmt_t'(r[12:8]));
				shiftCase(shFunc_t'(f), bw[0], bw[0] ? shAmt_t'(20) : shAmt_t'(12)); // past ring
			end
		end
		shiftCase(SH_RCL, 1'b1, shAmt_t'(16));
		shiftCase(SH_RCR, 1'b0, shAmt_t'(8));
	endtask

	task automatic divTests();
		logic [31:0] r;
		word_t den;
		byte_t d8;
		for (int i = 0; i < 4; i++)
		begin
			r   = nextRand();
			den = word_t'(r[31:16]) | 16'h0001; // never zero
			divCase(1'b1, word_t'(nextRand()) % den, word_t'(nextRand()), den, 0);
			d8  = byte_t'(r[7:0]) | 8'h01;
			divCase(1'b0, 16'h0000, {byte_t'(nextRand()) % d8, byte_t'(r[15:8])},
				{byte_t'(r[23:16]), d8}, 0);
		end
		divCase(1'b1, 16'h0001, 16'h2345, 16'h0000, 0); // divide by zero
		divCase(1'b1, 16'h1234, 16'h0000, 16'h0100, 0); // quotient too wide
		divCase(1'b0, 16'h0000, 16'h0012, 16'hff00, 0);
		divCase(1'b0, 16'h0000, 16'h8000, 16'h0010, 0);
		divCase(1'b1, 16'h0003, 16'hbeef, 16'h1234, 6); // stalled
		divCase(1'b0, 16'h0000, 16'h0a55, 16'h003c, 4);
	endtask

	initial
	begin
		rngState   = 32'h05e3_6ba3;
		errorCount = 0;
		rstN_i     = 1'b0;
		exec_i     = EXEC_NOP;
		func_i     = ALU_ADD;
		bw_i       = 1'b1;
		selIn1_i   = OPSEL_RF;
		selIn2_i   = OPSEL_RF;
		rf1_i      = 16'h0000;
		rf2_i      = 16'h0000;
		mem_i      = 16'h0000;
		imm1_i     = 16'h0000;
		imm2_i     = 16'h0000;
		dx_i       = 16'h0000;
		carry_i    = 1'b0;
		stall_i    = 1'b0;
		repeat (10) @(posedge iClk);
		rstN_i <= 1'b1;
		@(negedge iClk);
		resetCheck();
		aluTests();
		shiftTests();
		divTests();
		if (errorCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+hw
hw/execPkg.sv
hw/execAlu.sv
hw/execShifter.sv
hw/divCtrl.sv
hw/divStepCounter.sv
hw/divDatapath.sv
hw/execUnit.sv
sim/execUnitTb.sv

// ==== Bender.yml ====
package:
  name: exec_unit

export_include_dirs:
  - hw

sources:
  - files:
      - hw/execPkg.sv
      - hw/execAlu.sv
      - hw/execShifter.sv
      - hw/divCtrl.sv
      - hw/divStepCounter.sv
      - hw/divDatapath.sv
      - hw/execUnit.sv
  - target: simulation
    files:
      - sim/execUnitTb.sv
